// ==== design/hyper_pkg.sv ====
`default_nettype none

package hyper_pkg;

  // Number of Wishbone masters sharing the device
  localparam int unsigned NR_PORTS = 2;
  localparam int unsigned PORT_IDX_W = (NR_PORTS > 1) ? $clog2(NR_PORTS) : 1;

  localparam int unsigned WORD_ADDR_W = 22;

  // Command/address phase length in bytes
  localparam int unsigned CA_BYTES = 6;
  // clk_i cycles from last CA byte to first data byte (6 HyperBus clocks)
  localparam int unsigned LAT_CYCLES = 12;
  localparam int unsigned CNT_W = $clog2(LAT_CYCLES);

  typedef logic [WORD_ADDR_W-1:0] word_addr_t;
  typedef logic [15:0]            word_t;
  // Bit 1 selects the upper byte, which goes first on DQ
  typedef logic [1:0]             strb_t;
  typedef logic [7:0]             byte_t;
  typedef logic [8*CA_BYTES-1:0]  ca_t;
  typedef logic [PORT_IDX_W-1:0]  port_idx_t;
  typedef logic [CNT_W-1:0]       cnt_t;

  typedef struct packed {
    logic       cyc;
    logic       stb;
    logic       we;
    word_addr_t adr;
    word_t      dat;
    strb_t      sel;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  // One single-word HyperBus transaction
  typedef struct packed {
    logic       write;
    word_addr_t addr;
    word_t      wdata;
    strb_t      strb;
  } hyper_trans_t;

endpackage

`default_nettype wire

// ==== design/wb_port_arbiter.sv ====
`default_nettype none

module wb_port_arbiter (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  hyper_pkg::wb_req_t [hyper_pkg::NR_PORTS-1:0] req_i,
  output hyper_pkg::wb_rsp_t [hyper_pkg::NR_PORTS-1:0] rsp_o,
  output hyper_pkg::wb_req_t                           bus_req_o,
  input  hyper_pkg::wb_rsp_t                           bus_rsp_i
);
  import hyper_pkg::*;

  logic [NR_PORTS-1:0] cyc;
  logic [NR_PORTS-1:0] grant_d;
  logic [NR_PORTS-1:0] grant_q;
  port_idx_t           last_d;
  port_idx_t           last_q;
  logic                held;

  always_comb begin
    for (int i = 0; i < NR_PORTS; i++) begin
      cyc[i] = req_i[i].cyc;
    end
  end

  // Owner keeps the bus as long as its cycle is open
  assign held = |(grant_q & cyc);

  always_comb begin
    int unsigned idx;
    idx     = 0;
    grant_d = '0;
    last_d  = last_q;
    if (held) begin
      grant_d = grant_q;
    end else begin
      // Search starts at the port after the last one served
      for (int unsigned off = 1; off <= NR_PORTS; off++) begin
        idx = (off + last_q) % NR_PORTS;
        if (cyc[idx] && (grant_d == '0)) begin
          grant_d[idx] = 1'b1;
          last_d       = port_idx_t'(idx);
        end
      end
    end
  end

  always_comb begin
    bus_req_o = '0;
    for (int i = 0; i < NR_PORTS; i++) begin
      if (grant_d[i]) begin
        bus_req_o = req_i[i];
      end
    end
  end

  // Ack only reaches the registered owner
  always_comb begin
    for (int i = 0; i < NR_PORTS; i++) begin
      rsp_o[i].ack = bus_rsp_i.ack & grant_q[i];
      rsp_o[i].dat = bus_rsp_i.dat;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      grant_q <= '0;
      last_q  <= port_idx_t'(NR_PORTS - 1);
    end else begin
      grant_q <= grant_d;
      last_q  <= last_d;
    end
  end

endmodule

`default_nettype wire

// ==== design/hyper_wb_bridge.sv ====
`default_nettype none

module hyper_wb_bridge (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  hyper_pkg::wb_req_t      wb_req_i,
  output hyper_pkg::wb_rsp_t      wb_rsp_o,
  output hyper_pkg::hyper_trans_t trans_o,
  output logic                    trans_valid_o,
  input  logic                    trans_ready_i,
  input  logic                    done_i,
  input  hyper_pkg::word_t        rdata_i
);
  import hyper_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT,
    ST_ACK
  } state_e;

  state_e       state_d;
  state_e       state_q;
  hyper_trans_t trans_q;
  word_t        rdata_q;
  logic         take;

  assign take = (state_q == ST_IDLE) && wb_req_i.cyc && wb_req_i.stb;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (take) begin
          state_d = ST_REQ;
        end
      end
      ST_REQ: begin
        if (trans_ready_i) begin
          state_d = ST_WAIT;
        end
      end
      ST_WAIT: begin
        if (done_i) begin
          state_d = ST_ACK;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      trans_q.write <= wb_req_i.we;
      trans_q.addr  <= wb_req_i.adr;
      trans_q.wdata <= wb_req_i.dat;
      trans_q.strb  <= wb_req_i.sel;
    end
    if ((state_q == ST_WAIT) && done_i) begin
      rdata_q <= rdata_i;
    end
  end

  assign trans_o       = trans_q;
  assign trans_valid_o = (state_q == ST_REQ);
  assign wb_rsp_o.ack  = (state_q == ST_ACK);
  assign wb_rsp_o.dat  = rdata_q;

endmodule

`default_nettype wire

// ==== design/hyper_phy.sv ====
`default_nettype none

module hyper_phy (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  hyper_pkg::hyper_trans_t trans_i,
  input  logic                    trans_valid_i,
  output logic                    trans_ready_o,
  output logic                    done_o,
  output hyper_pkg::word_t        rdata_o,
  output logic                    hyper_cs_no,
  output logic                    hyper_ck_o,
  output logic                    hyper_ck_no,
  output logic                    hyper_reset_no,
  output hyper_pkg::byte_t        hyper_dq_o,
  output logic                    hyper_dq_oe_o,
  input  hyper_pkg::byte_t        hyper_dq_i,
  output logic                    hyper_rwds_o,
  output logic                    hyper_rwds_oe_o,
  input  logic                    hyper_rwds_i
);
  import hyper_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_LAT,
    ST_WDATA,
    ST_RDATA,
    ST_FINISH
  } state_e;

  state_e       state_d;
  state_e       state_q;
  cnt_t         cnt_d;
  cnt_t         cnt_q;
  hyper_trans_t trans_q;
  ca_t          ca_d;
  ca_t          ca_q;
  word_t        rdata_q;
  logic         rwds_prev_q;
  logic         rwds_edge;
  logic         bus_active;
  logic         ck_q;
  logic         accept;

  // Read, memory space, linear burst; address split as in the HyperBus spec
  assign ca_d = {~trans_i.write, 1'b0, 1'b1,
                 {(32 - WORD_ADDR_W){1'b0}}, trans_i.addr[WORD_ADDR_W-1:3],
                 13'b0, trans_i.addr[2:0]};

  assign accept    = (state_q == ST_IDLE) && trans_valid_i;
  assign rwds_edge = (hyper_rwds_i != rwds_prev_q);

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    case (state_q)
      ST_IDLE: begin
        if (trans_valid_i) begin
          state_d = ST_CMD;
          cnt_d   = '0;
        end
      end
      ST_CMD: begin
        cnt_d = cnt_q + 1'b1;
        if (cnt_q == cnt_t'(CA_BYTES - 1)) begin
          state_d = ST_LAT;
          cnt_d   = '0;
        end
      end
      ST_LAT: begin
        cnt_d = cnt_q + 1'b1;
        if (cnt_q == cnt_t'(LAT_CYCLES - 1)) begin
          state_d = trans_q.write ? ST_WDATA : ST_RDATA;
          cnt_d   = '0;
        end
      end
      ST_WDATA: begin
        cnt_d = cnt_q + 1'b1;
        if (cnt_q[0]) begin
          state_d = ST_FINISH;
          cnt_d   = '0;
        end
      end
      ST_RDATA: begin
        // Device toggles RWDS once per byte it puts on DQ
        if (rwds_edge) begin
          cnt_d = cnt_q + 1'b1;
          if (cnt_q[0]) begin
            state_d = ST_FINISH;
            cnt_d   = '0;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ST_IDLE;
      cnt_q       <= '0;
      rwds_prev_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      rwds_prev_q <= hyper_rwds_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      trans_q <= trans_i;
      ca_q    <= ca_d;
    end else if (state_q == ST_CMD) begin
      ca_q <= ca_q << 8;
    end
    if ((state_q == ST_RDATA) && rwds_edge) begin
      if (cnt_q[0]) begin
        rdata_q[7:0] <= hyper_dq_i;
      end else begin
        rdata_q[15:8] <= hyper_dq_i;
      end
    end
  end

  assign bus_active = (state_q == ST_CMD) || (state_q == ST_LAT) ||
                      (state_q == ST_WDATA) || (state_q == ST_RDATA);

  // Clock toggles mid-cycle so each DQ byte is stable across its edge
  always_ff @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ck_q <= 1'b0;
    end else if (bus_active) begin
      ck_q <= ~ck_q;
    end else begin
      ck_q <= 1'b0;
    end
  end

  assign hyper_cs_no    = ~bus_active;
  assign hyper_ck_o     = ck_q;
  assign hyper_ck_no    = ~ck_q;
  assign hyper_reset_no = rst_ni;

  always_comb begin
    hyper_dq_o = '0;
    if (state_q == ST_CMD) begin
      hyper_dq_o = ca_q[8*CA_BYTES-1 -: 8];
    end else if (state_q == ST_WDATA) begin
      hyper_dq_o = cnt_q[0] ? trans_q.wdata[7:0] : trans_q.wdata[15:8];
    end
  end

  assign hyper_dq_oe_o = (state_q == ST_CMD) || (state_q == ST_WDATA);

  // RWDS high masks the byte out of the write
  assign hyper_rwds_o    = (state_q == ST_WDATA) &&
                           (cnt_q[0] ? ~trans_q.strb[0] : ~trans_q.strb[1]);
  assign hyper_rwds_oe_o = (state_q == ST_WDATA);

  assign trans_ready_o = (state_q == ST_IDLE);
  assign done_o        = (state_q == ST_FINISH);
  assign rdata_o       = rdata_q;

endmodule

`default_nettype wire

// ==== design/hyper_subsys.sv ====
`default_nettype none

module hyper_subsys (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  hyper_pkg::wb_req_t [hyper_pkg::NR_PORTS-1:0] wb_req_i,
  output hyper_pkg::wb_rsp_t [hyper_pkg::NR_PORTS-1:0] wb_rsp_o,
  output logic                                         hyper_cs_no,
  output logic                                         hyper_ck_o,
  output logic                                         hyper_ck_no,
  output logic                                         hyper_reset_no,
  output hyper_pkg::byte_t                             hyper_dq_o,
  output logic                                         hyper_dq_oe_o,
  input  hyper_pkg::byte_t                             hyper_dq_i,
  output logic                                         hyper_rwds_o,
  output logic                                         hyper_rwds_oe_o,
  input  logic                                         hyper_rwds_i
);
  import hyper_pkg::*;

  wb_req_t      bus_req;
  wb_rsp_t      bus_rsp;
  hyper_trans_t trans;
  logic         trans_valid;
  logic         trans_ready;
  logic         done;
  word_t        rdata;

  wb_port_arbiter i_arbiter (
    .clk_i     ( clk_i    ),
    .rst_ni    ( rst_ni   ),
    .req_i     ( wb_req_i ),
    .rsp_o     ( wb_rsp_o ),
    .bus_req_o ( bus_req  ),
    .bus_rsp_i ( bus_rsp  )
  );

  hyper_wb_bridge i_bridge (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .wb_req_i      ( bus_req     ),
    .wb_rsp_o      ( bus_rsp     ),
    .trans_o       ( trans       ),
    .trans_valid_o ( trans_valid ),
    .trans_ready_i ( trans_ready ),
    .done_i        ( done        ),
    .rdata_i       ( rdata       )
  );

  hyper_phy i_phy (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .trans_i         ( trans           ),
    .trans_valid_i   ( trans_valid     ),
    .trans_ready_o   ( trans_ready     ),
    .done_o          ( done            ),
    .rdata_o         ( rdata           ),
    .hyper_cs_no     ( hyper_cs_no     ),
    .hyper_ck_o      ( hyper_ck_o      ),
    .hyper_ck_no     ( hyper_ck_no     ),
    .hyper_reset_no  ( hyper_reset_no  ),
    .hyper_dq_o      ( hyper_dq_o      ),
    .hyper_dq_oe_o   ( hyper_dq_oe_o   ),
    .hyper_dq_i      ( hyper_dq_i      ),
    .hyper_rwds_o    ( hyper_rwds_o    ),
    .hyper_rwds_oe_o ( hyper_rwds_oe_o ),
    .hyper_rwds_i    ( hyper_rwds_i    )
  );

endmodule

`default_nettype wire

// ==== tests/hyperram_model.sv ====
`default_nettype none

module hyperram_model (
  input  logic             cs_ni,
  input  logic             ck_i,
  input  hyper_pkg::byte_t dq_i,
  input  logic             rwds_i,
  output hyper_pkg::byte_t dq_o,
  output logic             dq_oe_o,
  output logic             rwds_o,
  output logic             rwds_oe_o,
  output int unsigned      err_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import hyper_pkg::*;

  // First ck edge that carries a data byte
  localparam int unsigned DATA_EDGE = CA_BYTES + LAT_CYCLES;

  word_t       mem [word_addr_t];
  ca_t         ca;
  int unsigned edge_idx;
  logic        is_read;
  word_addr_t  addr;
  word_t       cur;

  // Unwritten words read back as a pattern of their full address
  function automatic word_t fill_word(input word_addr_t a);
    return a[15:0] ^ {a[21:16], a[21:12]};
  endfunction

  task automatic report_malformed(input string what);
    err_cnt_o++;
    $display("Model at %0t ns: malformed command, %s (CA %h)", $time, what, ca);
  endtask

  task automatic decode_command();
    is_read = ca[47];
    addr    = {ca[34:16], ca[2:0]};
    if ($isunknown(ca)) begin
      report_malformed("unknown bits in command/address");
    end
    if (ca[46] !== 1'b0) begin
      report_malformed("register space requested instead of memory");
    end
    if (ca[45] !== 1'b1) begin
      report_malformed("wrapped burst requested instead of linear");
    end
    if ((ca[44:35] !== '0) || (ca[15:3] !== '0)) begin
      report_malformed("reserved address bits are not zero");
    end
    cur = mem.exists(addr) ? mem[addr] : fill_word(addr);
  endtask

  initial begin
    dq_o      = '0;
    dq_oe_o   = 1'b0;
    rwds_o    = 1'b0;
    rwds_oe_o = 1'b0;
    err_cnt_o = 0;
    edge_idx  = 0;
    ca        = '0;
  end

  // Both ck edges qualify a byte while CS is low
  always @(posedge ck_i or negedge ck_i or posedge cs_ni) begin
    if (cs_ni !== 1'b0) begin
      edge_idx  = 0;
      dq_o      = '0;
      dq_oe_o   = 1'b0;
      rwds_o    = 1'b0;
      rwds_oe_o = 1'b0;
    end else begin
      if (edge_idx < CA_BYTES) begin
        ca = {ca[8*CA_BYTES-9:0], dq_i};
        if (edge_idx == CA_BYTES - 1) begin
          decode_command();
        end
      end else if (is_read) begin
        // Two cycles per byte, RWDS toggles with each one
        if (edge_idx == DATA_EDGE) begin
          dq_o      = cur[15:8];
          dq_oe_o   = 1'b1;
          rwds_o    = 1'b1;
          rwds_oe_o = 1'b1;
        end else if (edge_idx == DATA_EDGE + 2) begin
          dq_o   = cur[7:0];
          rwds_o = 1'b0;
        end
      end else begin
        // RWDS high masks the byte
        if ((edge_idx == DATA_EDGE) && !rwds_i) begin
          cur[15:8] = dq_i;
        end
        if (edge_idx == DATA_EDGE + 1) begin
          if (!rwds_i) begin
            cur[7:0] = dq_i;
          end
          mem[addr] = cur;
        end
      end
      edge_idx++;
    end
  end

endmodule

`default_nettype wire

// ==== tests/hyper_subsys_tb.sv ====
`default_nettype none

module hyper_subsys_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import hyper_pkg::*;

  localparam int CLK_PERIOD    = 100;
  localparam int RANDOM_OPS    = 200;
  localparam int CYCLES_PER_OP = 60;
  localparam int ACK_TIMEOUT   = 100;
  localparam int WRITE_ACK_LAT = 22;

  logic                   clk_i;
  logic                   rst_ni;
  wb_req_t [NR_PORTS-1:0] wb_req;
  wb_rsp_t [NR_PORTS-1:0] wb_rsp;
  logic                   hyper_cs_no;
  logic                   hyper_ck_o;
  logic                   hyper_ck_no;
  logic                   hyper_reset_no;
  byte_t                  hyper_dq_o;
  logic                   hyper_dq_oe_o;
  logic                   hyper_rwds_o;
  logic                   hyper_rwds_oe_o;
  byte_t                  dq_bus;
  logic                   rwds_bus;
  byte_t                  model_dq;
  logic                   model_dq_oe;
  logic                   model_rwds;
  logic                   model_rwds_oe;
  int unsigned            model_errors;

  logic [31:0]  lfsr_state;
  word_t        sb_mem [word_addr_t];
  int unsigned  data_errors;
  int unsigned  pin_errors;
  int unsigned  lat_errors;
  int unsigned  hs_errors;
  int           last_served;
  int           ack_order[$];
  int unsigned  cyc_cnt;
  int unsigned  cs_fall_cyc;
  logic         cs_prev;
  logic         saw_write;

  // Resolved tristate buses, pulled low when nobody drives
  assign dq_bus   = hyper_dq_oe_o ? hyper_dq_o : (model_dq_oe ? model_dq : 8'h00);
  assign rwds_bus = hyper_rwds_oe_o ? hyper_rwds_o : (model_rwds_oe ? model_rwds : 1'b0);

  hyper_subsys DUT (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .wb_req_i        ( wb_req          ),
    .wb_rsp_o        ( wb_rsp          ),
    .hyper_cs_no     ( hyper_cs_no     ),
    .hyper_ck_o      ( hyper_ck_o      ),
    .hyper_ck_no     ( hyper_ck_no     ),
    .hyper_reset_no  ( hyper_reset_no  ),
    .hyper_dq_o      ( hyper_dq_o      ),
    .hyper_dq_oe_o   ( hyper_dq_oe_o   ),
    .hyper_dq_i      ( dq_bus          ),
    .hyper_rwds_o    ( hyper_rwds_o    ),
    .hyper_rwds_oe_o ( hyper_rwds_oe_o ),
    .hyper_rwds_i    ( rwds_bus        )
  );

  hyperram_model u_model (
    .cs_ni     ( hyper_cs_no   ),
    .ck_i      ( hyper_ck_o    ),
    .dq_i      ( dq_bus        ),
    .rwds_i    ( rwds_bus      ),
    .dq_o      ( model_dq      ),
    .dq_oe_o   ( model_dq_oe   ),
    .rwds_o    ( model_rwds    ),
    .rwds_oe_o ( model_rwds_oe ),
    .err_cnt_o ( model_errors  )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      val        = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  function automatic word_t fill_word(input word_addr_t a);
    return a[15:0] ^ {a[21:16], a[21:12]};
  endfunction

  function automatic word_t lookup_word(input word_addr_t a);
    if (sb_mem.exists(a)) begin
      return sb_mem[a];
    end
    return fill_word(a);
  endfunction

  function automatic void merge_word(input word_addr_t a, input word_t d, input strb_t sel);
    word_t w;
    w = lookup_word(a);
    if (sel[1]) begin
      w[15:8] = d[15:8];
    end
    if (sel[0]) begin
      w[7:0] = d[7:0];
    end
    sb_mem[a] = w;
  endfunction

  // Pins must be quiet whenever CS is high
  assert property (@(posedge clk_i) disable iff (!rst_ni) hyper_cs_no |-> !hyper_ck_o)
    else begin
      pin_errors++;
      $display("Error at %0t ns: hyper_ck_o = %b, expected 0", $time, $sampled(hyper_ck_o));
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   hyper_cs_no |-> !(hyper_dq_oe_o || hyper_rwds_oe_o))
    else begin
      pin_errors++;
      $display("Error at %0t ns: hyper_dq_oe_o/hyper_rwds_oe_o = %b%b, expected 00",
               $time, $sampled(hyper_dq_oe_o), $sampled(hyper_rwds_oe_o));
    end

  // Differential clock pair stays complementary
  assert property (@(posedge clk_i) disable iff (!rst_ni) hyper_ck_no == !hyper_ck_o)
    else begin
      pin_errors++;
      $display("Error at %0t ns: hyper_ck_no = %b, expected %b",
               $time, $sampled(hyper_ck_no), !$sampled(hyper_ck_o));
    end

  // Write ack latency, counted from the transfer cycle before CS falls
  always @(negedge clk_i) begin
    cyc_cnt++;
    if ((cs_prev === 1'b1) && (hyper_cs_no === 1'b0)) begin
      cs_fall_cyc = cyc_cnt;
      saw_write   = 1'b0;
    end
    if (hyper_rwds_oe_o) begin
      saw_write = 1'b1;
    end
    if (saw_write && (wb_rsp[0].ack || wb_rsp[1].ack)) begin
      assert (cyc_cnt - cs_fall_cyc + 1 == WRITE_ACK_LAT)
        else begin
          lat_errors++;
          $display("Error at %0t ns: write ack latency = %0d, expected %0d",
                   $time, cyc_cnt - cs_fall_cyc + 1, WRITE_ACK_LAT);
        end
      saw_write = 1'b0;
    end
    cs_prev = hyper_cs_no;
  end

  task automatic expect_pin(input string name, input logic actual, input logic expected);
    assert (actual === expected)
      else begin
        pin_errors++;
        $display("Error at %0t ns: %s = %b, expected %b", $time, name, actual, expected);
      end
  endtask

  task automatic idle_pins();
    expect_pin("hyper_cs_no", hyper_cs_no, 1'b1);
    expect_pin("hyper_ck_o", hyper_ck_o, 1'b0);
    expect_pin("hyper_dq_oe_o", hyper_dq_oe_o, 1'b0);
    expect_pin("hyper_rwds_oe_o", hyper_rwds_oe_o, 1'b0);
  endtask

  task automatic wb_access(input int port, input logic we, input word_addr_t adr,
                           input word_t dat, input strb_t sel, output word_t rdat);
    wb_req_t req;
    int      waited;
    logic    acked;
    waited = 0;
    acked  = 1'b0;
    req    = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    @(negedge clk_i);
    wb_req[port] = req;
    while (!acked && (waited < ACK_TIMEOUT)) begin
      @(negedge clk_i);
      waited++;
      acked = wb_rsp[port].ack;
    end
    rdat         = wb_rsp[port].dat;
    wb_req[port] = '0;
    if (acked) begin
      last_served = port;
      ack_order.push_back(port);
    end else begin
      hs_errors++;
      $display("Port %0d got no ack within %0d cycles", port, ACK_TIMEOUT);
    end
  endtask

  task automatic write_word(input int port, input word_addr_t a, input word_t d,
                            input strb_t sel);
    word_t unused;
    wb_access(port, 1'b1, a, d, sel, unused);
    merge_word(a, d, sel);
  endtask

  task automatic read_word(input int port, input word_addr_t a);
    word_t rdat;
    word_t exp;
    wb_access(port, 1'b0, a, '0, 2'b11, rdat);
    exp = lookup_word(a);
    assert (rdat === exp)
      else begin
        data_errors++;
        $display("Error at %0t ns: wb_rsp_o[%0d].dat = %h, expected %h",
                 $time, port, rdat, exp);
      end
  endtask

  task automatic expect_first_ack(input int first);
    assert ((ack_order.size() == 2) && (ack_order[0] == first))
      else begin
        hs_errors++;
        $display("Round-robin order wrong, port %0d should have been acked first", first);
      end
  endtask

  task automatic arbitrate_pair(input word_addr_t a0, input word_addr_t a1);
    int first;
    first = (last_served + 1) % NR_PORTS;
    ack_order.delete();
    fork
      write_word(0, a0, 16'hC0DE, 2'b11);
      write_word(1, a1, 16'hBEEF, 2'b11);
    join
    expect_first_ack(first);
    // A lone port 1 access makes port 0 the next in turn
    read_word(1, a0);
    first = (last_served + 1) % NR_PORTS;
    ack_order.delete();
    fork
      read_word(0, a1);
      read_word(1, a0);
    join
    expect_first_ack(first);
  endtask

  initial begin
    logic [31:0] r_port;
    logic [31:0] r_we;
    logic [31:0] r_hi;
    logic [31:0] r_lo;
    logic [31:0] r_dat;
    logic [31:0] r_sel;
    word_addr_t  adr;
    int unsigned total;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    wb_req      = '0;
    lfsr_state  = 32'he708;
    data_errors = 0;
    pin_errors  = 0;
    lat_errors  = 0;
    hs_errors   = 0;
    cyc_cnt     = 0;
    cs_fall_cyc = 0;
    cs_prev     = 1'b1;
    saw_write   = 1'b0;
    last_served = NR_PORTS - 1;
    repeat (4) @(negedge clk_i);
    expect_pin("hyper_reset_no", hyper_reset_no, 1'b0);
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    idle_pins();
    expect_pin("hyper_reset_no", hyper_reset_no, 1'b1);

    write_word(0, 22'h2ABCDE, 16'h5A3C, 2'b11);
    read_word(0, 22'h2ABCDE);

    write_word(0, 22'h01F00D, 16'hA5C3, 2'b11);
    write_word(0, 22'h01F00D, 16'h1234, 2'b10);
    read_word(0, 22'h01F00D);
    write_word(0, 22'h01F00D, 16'h5678, 2'b01);
    read_word(0, 22'h01F00D);

    arbitrate_pair(22'h3F0001, 22'h000007);
    @(negedge clk_i);
    idle_pins();

    // Small address pool so reads often hit earlier writes
    for (int i = 0; i < RANDOM_OPS; i++) begin
      r_port = rand_bits(1);
      r_we   = rand_bits(1);
      r_hi   = rand_bits(3);
      r_lo   = rand_bits(4);
      adr    = {r_hi[2:0], 15'h0, r_lo[3:0]};
      if (r_we[0]) begin
        r_dat = rand_bits(16);
        r_sel = rand_bits(2);
        write_word(int'(r_port), adr, r_dat[15:0], r_sel[1:0]);
      end else begin
        read_word(int'(r_port), adr);
      end
    end

    repeat (4) @(negedge clk_i);
    idle_pins();
    total = data_errors + pin_errors + lat_errors + hs_errors + model_errors;
    $display("Error counts: data %0d, pins %0d, ack latency %0d, handshake %0d, model %0d",
             data_errors, pin_errors, lat_errors, hs_errors, model_errors);
    if (total == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(RANDOM_OPS * CYCLES_PER_OP * CLK_PERIOD);
    $display("Timeout, the run did not finish in %0d cycles", RANDOM_OPS * CYCLES_PER_OP);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/hyper_pkg.sv
design/wb_port_arbiter.sv
design/hyper_wb_bridge.sv
design/hyper_phy.sv
design/hyper_subsys.sv
tests/hyperram_model.sv
tests/hyper_subsys_tb.sv

// ==== Makefile ====
TOP := hyper_subsys_tb

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f vlog.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "^Everything OK$$" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module hyper_subsys -f vlog.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
